// ==== src/rv_core_pkg.sv ====
// ------------------------------------------------
// Shared types and encodings of the RV32I core,
// imported by every RTL unit and the testbench
// ------------------------------------------------

package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // ALU operations executed in stage 2
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  // Writeback source
  typedef enum logic {
    WB_ALU       = 1'b0,
    WB_UPPER_IMM = 1'b1
  } wb_sel_t;

  // Major opcodes
  // ------------------------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  // funct3 values
  // ------------------------------------------------
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam word_t PC_STEP = 32'd4;

endpackage

// ==== src/fetch_ctrl_if.sv ====
// ------------------------------------------------
// Fetch control bundle between fetch and execute
// ------------------------------------------------

`timescale 1ns/1ps

interface fetch_ctrl_if
  import rv_core_pkg::*;
();

  word_t pc_s1;
  logic  clock_enable;
  logic  take_branch_s1;
  word_t target_address_s1;

  modport fetch (
    output pc_s1,
    output clock_enable,
    input  take_branch_s1,
    input  target_address_s1
  );

  modport execute (
    input  pc_s1,
    input  clock_enable,
    output take_branch_s1,
    output target_address_s1
  );

endinterface

// ==== src/decode_if.sv ====
// ------------------------------------------------
// Decoded stage-1 control fields, from the decoder
// to the execute stage and the store port
// ------------------------------------------------

`timescale 1ns/1ps

interface decode_if
  import rv_core_pkg::*;
();

  alu_op_t   alu_op;
  wb_sel_t   wb_sel;
  logic      use_imm;
  word_t     immediate;
  reg_addr_t rd_address;
  logic      reg_write;
  logic      branch;
  logic      branch_ne;
  logic      store;

  modport decoder (
    output alu_op, wb_sel, use_imm, immediate, rd_address,
    output reg_write, branch, branch_ne, store
  );

  modport consumer (
    input alu_op, wb_sel, use_imm, immediate, rd_address,
    input reg_write, branch, branch_ne, store
  );

endinterface

// ==== src/rv_fetch_unit.sv ====
// ------------------------------------------------
// Program counter, instruction bus master and the
// global clock enable of the pipeline
// ------------------------------------------------

`timescale 1ns/1ps

module rv_fetch_unit
  import rv_core_pkg::*;
#(
  parameter word_t BOOT_ADDRESS = 32'h0000_0000
) (
  input  logic  clock,
  input  logic  reset_n,
  input  word_t ibus_rdata,
  input  logic  ibus_rresponse,
  output word_t ibus_address,
  output logic  ibus_rrequest,
  input  logic  store_pending,
  fetch_ctrl_if.fetch ctrl,
  output word_t instruction_s1
);

  // addi x0, x0, 0
  localparam word_t NOP_INSTRUCTION = 32'h0000_0013;

  logic  first_fetch;
  logic  fetch_pending;
  logic  clock_enable;
  word_t pc_s0;
  word_t pc_s1;

  // Pipeline advances only with nothing outstanding on either bus
  assign clock_enable      = !fetch_pending && !store_pending;
  assign ctrl.clock_enable = clock_enable;
  assign ctrl.pc_s1        = pc_s1;

  // Stage 0
  // ------------------------------------------------
  always_comb begin
    if (first_fetch) begin
      pc_s0 = BOOT_ADDRESS;
    end else if (ctrl.take_branch_s1) begin
      pc_s0 = ctrl.target_address_s1;
    end else begin
      pc_s0 = pc_s1 + PC_STEP;
    end
  end

  // The request address is the stage-1 PC, held until the next advance
  assign ibus_address = pc_s1;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      first_fetch    <= 1'b1;
      fetch_pending  <= 1'b0;
      ibus_rrequest  <= 1'b0;
      pc_s1          <= BOOT_ADDRESS;
      instruction_s1 <= NOP_INSTRUCTION;
    end else begin
      ibus_rrequest <= clock_enable;
      if (clock_enable) begin
        first_fetch    <= 1'b0;
        fetch_pending  <= 1'b1;
        pc_s1          <= pc_s0;
        // Slot is empty until its instruction arrives
        instruction_s1 <= NOP_INSTRUCTION;
      end else if (fetch_pending && ibus_rresponse) begin
        fetch_pending  <= 1'b0;
        instruction_s1 <= ibus_rdata;
      end
    end
  end

  // One fetch in flight at a time
  a_single_fetch : assert property (
    @(posedge clock) disable iff (!reset_n)
    ibus_rrequest |=> (!ibus_rrequest until_with ibus_rresponse)
  );

endmodule

// ==== src/rv_decoder.sv ====
// ------------------------------------------------
// Stage-1 instruction decoder and immediate builder
// ------------------------------------------------

`timescale 1ns/1ps

module rv_decoder
  import rv_core_pkg::*;
(
  input  word_t     instruction_s1,
  output reg_addr_t rs1_address,
  output reg_addr_t rs2_address,
  decode_if.decoder dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_alt;
  reg_addr_t  rd_field;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;

  // Map funct3 to an ALU operation, sub only for register operands
  function automatic alu_op_t alu_from_funct(
    input logic [2:0] f3,
    input logic       alt,
    input logic       allow_sub
  );
    alu_op_t op;
    case (f3)
      F3_ADD_SUB: op = (alt && allow_sub) ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
      default:    op = ALU_ADD;
    endcase
    return op;
  endfunction

  // Instruction fields
  assign opcode      = instruction_s1[6:0];
  assign funct3      = instruction_s1[14:12];
  assign funct7_alt  = instruction_s1[30];
  assign rd_field    = instruction_s1[11:7];
  assign rs1_address = instruction_s1[19:15];
  assign rs2_address = instruction_s1[24:20];

  // Immediates
  // ------------------------------------------------
  assign imm_i = {{20{instruction_s1[31]}}, instruction_s1[31:20]};
  assign imm_s = {{20{instruction_s1[31]}}, instruction_s1[31:25], instruction_s1[11:7]};
  assign imm_b = {{19{instruction_s1[31]}}, instruction_s1[31], instruction_s1[7],
                  instruction_s1[30:25], instruction_s1[11:8], 1'b0};
  assign imm_u = {instruction_s1[31:12], 12'h000};

  // Control fields
  // ------------------------------------------------
  always_comb begin
    dec.alu_op     = ALU_ADD;
    dec.wb_sel     = WB_ALU;
    dec.use_imm    = 1'b0;
    dec.immediate  = imm_i;
    dec.rd_address = rd_field;
    dec.reg_write  = 1'b0;
    dec.branch     = 1'b0;
    dec.branch_ne  = 1'b0;
    dec.store      = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        dec.reg_write = 1'b1;
        dec.alu_op    = alu_from_funct(funct3, funct7_alt, 1'b1);
      end
      OPCODE_OP_IMM: begin
        dec.reg_write = 1'b1;
        dec.use_imm   = 1'b1;
        dec.alu_op    = alu_from_funct(funct3, funct7_alt, 1'b0);
      end
      OPCODE_LUI: begin
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_UPPER_IMM;
        dec.immediate = imm_u;
      end
      OPCODE_STORE: begin
        dec.immediate = imm_s;
        dec.store     = (funct3 == F3_SW);
      end
      OPCODE_BRANCH: begin
        dec.immediate = imm_b;
        dec.branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        dec.branch_ne = (funct3 == F3_BNE);
      end
      // everything else falls through as a no-op
      default: ;
    endcase
  end

endmodule

// ==== src/rv_register_file.sv ====
// ------------------------------------------------
// Integer register file, x1 to x31, with bypass
// ------------------------------------------------

`timescale 1ns/1ps

module rv_register_file
  import rv_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset_n,
  input  logic      clock_enable,
  input  reg_addr_t rs1_address,
  input  reg_addr_t rs2_address,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  reg_addr_t rd_address,
  input  word_t     rd_data,
  input  logic      write_request
);

  word_t registers [1:31];
  logic  write_valid;

  // x0 never written
  assign write_valid = write_request && (rd_address != 5'd0);

  always_ff @(posedge clock) begin
    if (reset_n && clock_enable && write_valid) begin
      registers[rd_address] <= rd_data;
    end
  end

  // Read ports, stage-2 write forwarded to stage 1
  assign rs1_data = (rs1_address == 5'd0)                           ? '0 :
                    (write_valid && (rd_address == rs1_address))   ? rd_data :
                                                                     registers[rs1_address];
  assign rs2_data = (rs2_address == 5'd0)                           ? '0 :
                    (write_valid && (rd_address == rs2_address))   ? rd_data :
                                                                     registers[rs2_address];

endmodule

// ==== src/rv_execute_stage.sv ====
// ------------------------------------------------
// Branch resolution and address adder in stage 1,
// ALU and writeback selection in stage 2
// ------------------------------------------------

`timescale 1ns/1ps

module rv_execute_stage
  import rv_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset_n,
  fetch_ctrl_if.execute ctrl,
  decode_if.consumer    dec,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_addr_t rd_address,
  output word_t     rd_data,
  output logic      write_request,
  output word_t     target_address_s1
);

  logic      operands_equal;
  word_t     adder_base;

  alu_op_t   alu_op_s2;
  wb_sel_t   wb_sel_s2;
  logic      use_imm_s2;
  word_t     immediate_s2;
  reg_addr_t rd_address_s2;
  logic      reg_write_s2;
  word_t     rs1_data_s2;
  word_t     rs2_data_s2;
  word_t     operand_b;
  logic [4:0] shamt;
  word_t     alu_result;

  // Stage 1
  // ------------------------------------------------
  assign operands_equal      = (rs1_data == rs2_data);
  assign ctrl.take_branch_s1 = dec.branch && (dec.branch_ne ? !operands_equal : operands_equal);

  // Store address from rs1, branch target from the PC
  assign adder_base             = dec.store ? rs1_data : ctrl.pc_s1;
  assign target_address_s1      = adder_base + dec.immediate;
  assign ctrl.target_address_s1 = target_address_s1;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      reg_write_s2 <= 1'b0;
    end else if (ctrl.clock_enable) begin
      reg_write_s2 <= dec.reg_write;
    end
  end

  always_ff @(posedge clock) begin
    if (ctrl.clock_enable) begin
      alu_op_s2     <= dec.alu_op;
      wb_sel_s2     <= dec.wb_sel;
      use_imm_s2    <= dec.use_imm;
      immediate_s2  <= dec.immediate;
      rd_address_s2 <= dec.rd_address;
      rs1_data_s2   <= rs1_data;
      rs2_data_s2   <= rs2_data;
    end
  end

  // Stage 2
  // ------------------------------------------------
  assign operand_b = use_imm_s2 ? immediate_s2 : rs2_data_s2;
  assign shamt     = operand_b[4:0];

  always_comb begin
    case (alu_op_s2)
      ALU_ADD:  alu_result = rs1_data_s2 + operand_b;
      ALU_SUB:  alu_result = rs1_data_s2 - operand_b;
      ALU_SLL:  alu_result = rs1_data_s2 << shamt;
      ALU_SLT:  alu_result = {31'b0, $signed(rs1_data_s2) < $signed(operand_b)};
      ALU_SLTU: alu_result = {31'b0, rs1_data_s2 < operand_b};
      ALU_XOR:  alu_result = rs1_data_s2 ^ operand_b;
      ALU_SRL:  alu_result = rs1_data_s2 >> shamt;
      ALU_SRA:  alu_result = word_t'($signed(rs1_data_s2) >>> shamt);
      ALU_OR:   alu_result = rs1_data_s2 | operand_b;
      ALU_AND:  alu_result = rs1_data_s2 & operand_b;
      default:  alu_result = rs1_data_s2 + operand_b;
    endcase
  end

  assign rd_data       = (wb_sel_s2 == WB_UPPER_IMM) ? immediate_s2 : alu_result;
  assign rd_address    = rd_address_s2;
  assign write_request = reg_write_s2;

endmodule

// ==== src/rv_store_port.sv ====
// ------------------------------------------------
// Data bus write master, one SW at a time
// ------------------------------------------------

`timescale 1ns/1ps

module rv_store_port
  import rv_core_pkg::*;
(
  input  logic  clock,
  input  logic  reset_n,
  decode_if.consumer dec,
  input  word_t rs2_data,
  input  word_t target_address_s1,
  input  logic  clock_enable,
  input  logic  dbus_wresponse,
  output word_t dbus_address,
  output word_t dbus_wdata,
  output logic  dbus_wrequest,
  output logic  store_pending
);

  logic store_outstanding;
  logic store_done;
  logic issue_store;

  // Issue once per store sitting in stage 1
  assign issue_store   = dec.store && !store_outstanding && !store_done;
  // Holds the pipeline from issue until the response
  assign store_pending = dec.store && !store_done;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      dbus_wrequest     <= 1'b0;
      store_outstanding <= 1'b0;
      store_done        <= 1'b0;
    end else begin
      dbus_wrequest <= issue_store;
      if (issue_store) begin
        store_outstanding <= 1'b1;
      end else if (dbus_wresponse) begin
        store_outstanding <= 1'b0;
      end
      if (clock_enable) begin
        store_done <= 1'b0;
      end else if (store_outstanding && dbus_wresponse) begin
        store_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue_store) begin
      dbus_address <= target_address_s1;
      dbus_wdata   <= rs2_data;
    end
  end

  a_store_stable : assert property (
    @(posedge clock) disable iff (!reset_n)
    (store_outstanding && !dbus_wresponse) |=> ($stable(dbus_address) && $stable(dbus_wdata))
  );

endmodule

// ==== src/rv_core_top.sv ====
// ------------------------------------------------
// Two-stage RV32I subset core, instruction bus and
// data bus write side as plain ports
// ------------------------------------------------

`timescale 1ns/1ps

module rv_core_top
  import rv_core_pkg::*;
#(
  parameter word_t BOOT_ADDRESS = 32'h0000_0000
) (
  input  logic  clock,
  input  logic  reset_n,
  input  word_t ibus_rdata,
  input  logic  ibus_rresponse,
  output word_t ibus_address,
  output logic  ibus_rrequest,
  input  logic  dbus_wresponse,
  output word_t dbus_address,
  output word_t dbus_wdata,
  output logic  dbus_wrequest
);

  word_t     instruction_s1;
  reg_addr_t rs1_address;
  reg_addr_t rs2_address;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd_address;
  word_t     rd_data;
  logic      write_request;
  word_t     target_address_s1;
  logic      store_pending;

  fetch_ctrl_if ctrl_bus ();
  decode_if     dec_bus ();

  rv_fetch_unit #(
    .BOOT_ADDRESS(BOOT_ADDRESS)
  ) fetch_unit (
    .clock         (clock),
    .reset_n       (reset_n),
    .ibus_rdata    (ibus_rdata),
    .ibus_rresponse(ibus_rresponse),
    .ibus_address  (ibus_address),
    .ibus_rrequest (ibus_rrequest),
    .store_pending (store_pending),
    .ctrl          (ctrl_bus.fetch),
    .instruction_s1(instruction_s1)
  );

  rv_decoder decoder (
    .instruction_s1(instruction_s1),
    .rs1_address   (rs1_address),
    .rs2_address   (rs2_address),
    .dec           (dec_bus.decoder)
  );

  rv_register_file register_file (
    .clock        (clock),
    .reset_n      (reset_n),
    .clock_enable (ctrl_bus.clock_enable),
    .rs1_address  (rs1_address),
    .rs2_address  (rs2_address),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .rd_address   (rd_address),
    .rd_data      (rd_data),
    .write_request(write_request)
  );

  rv_execute_stage execute_stage (
    .clock            (clock),
    .reset_n          (reset_n),
    .ctrl             (ctrl_bus.execute),
    .dec              (dec_bus.consumer),
    .rs1_data         (rs1_data),
    .rs2_data         (rs2_data),
    .rd_address       (rd_address),
    .rd_data          (rd_data),
    .write_request    (write_request),
    .target_address_s1(target_address_s1)
  );

  rv_store_port store_port (
    .clock            (clock),
    .reset_n          (reset_n),
    .dec              (dec_bus.consumer),
    .rs2_data         (rs2_data),
    .target_address_s1(target_address_s1),
    .clock_enable     (ctrl_bus.clock_enable),
    .dbus_wresponse   (dbus_wresponse),
    .dbus_address     (dbus_address),
    .dbus_wdata       (dbus_wdata),
    .dbus_wrequest    (dbus_wrequest),
    .store_pending    (store_pending)
  );

endmodule

// ==== test/rv_core_checker.sv ====
// ------------------------------------------------
// Bus monitor of the core, compares every fetch and
// store in order against the expected sequences
// ------------------------------------------------

`timescale 1ns/1ps

module rv_core_checker
  import rv_core_pkg::*;
#(
  parameter int HALT_FETCHES = 3
) (
  input  logic  clock,
  input  logic  reset_n,
  input  logic  ibus_rrequest,
  input  word_t ibus_address,
  input  logic  dbus_wrequest,
  input  word_t dbus_address,
  input  word_t dbus_wdata,
  output logic  done
);

  word_t fetch_expected [$];
  word_t store_address_expected [$];
  word_t store_data_expected [$];
  int    fetch_count = 0;
  int    store_count = 0;
  int    check_count = 0;
  int    error_count = 0;

  task automatic expect_fetch(input word_t address);
    fetch_expected.push_back(address);
  endtask

  task automatic expect_store(input word_t address, input word_t data);
    store_address_expected.push_back(address);
    store_data_expected.push_back(data);
  endtask

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  // Bus outputs are registered, so the values before the edge are settled
  always @(posedge clock) begin
    if (!reset_n) begin
      if (ibus_rrequest === 1'b1 || dbus_wrequest === 1'b1) begin
        error_count++;
        $display("A bus request was issued at %0t while reset was asserted", $time);
      end
    end else begin
      if (ibus_rrequest) begin
        if (fetch_count < fetch_expected.size()) begin
          compare_word("ibus_address", fetch_expected[fetch_count], ibus_address);
        end else begin
          // Halt loop keeps refetching its own address
          compare_word("ibus_address", fetch_expected[fetch_expected.size() - 1],
                       ibus_address);
        end
        fetch_count++;
      end
      if (dbus_wrequest) begin
        if (store_count < store_address_expected.size()) begin
          compare_word("dbus_address", store_address_expected[store_count], dbus_address);
          compare_word("dbus_wdata", store_data_expected[store_count], dbus_wdata);
        end else begin
          error_count++;
          $display("An extra store was issued at %0t to address %h", $time, dbus_address);
        end
        store_count++;
      end
    end
    done = (fetch_count >= fetch_expected.size() + HALT_FETCHES);
  end

  task automatic close_report();
    if (store_count < store_address_expected.size()) begin
      error_count++;
      $display("Stores are missing: %0d expected but only %0d issued",
               store_address_expected.size(), store_count);
    end
    $display("Checks %0d, errors %0d, fetches %0d, stores %0d",
             check_count, error_count, fetch_count, store_count);
  endtask

endmodule

// ==== test/tb_rv_core.sv ====
// ------------------------------------------------
// Testbench of the core with instruction memory,
// bus responders with random delays and a watchdog
// ------------------------------------------------

`timescale 1ns/1ps

module tb_rv_core
  import rv_core_pkg::*;
();

  localparam word_t BOOT_ADDRESS = 32'h0000_0100;
  localparam int    RESET_CYCLES = 10;
  localparam int    MAX_DELAY    = 4;
  localparam int    HALT_FETCHES = 3;
  localparam int    MEMORY_WORDS = 64;

  logic  clock;
  logic  reset_n;
  word_t ibus_rdata;
  logic  ibus_rresponse;
  word_t ibus_address;
  logic  ibus_rrequest;
  logic  dbus_wresponse;
  word_t dbus_address;
  word_t dbus_wdata;
  logic  dbus_wrequest;
  logic  program_done;

  logic [31:0] lfsr_state = 32'hf97e_9246;
  word_t       program_memory [0:MEMORY_WORDS-1];

  // Program table, one row per word from BOOT_ADDRESS up
  word_t table_word [$];
  bit    table_fetched [$];
  bit    table_store [$];
  word_t table_store_address [$];
  word_t table_store_data [$];

  rv_core_top #(
    .BOOT_ADDRESS(BOOT_ADDRESS)
  ) UUT (.*);

  rv_core_checker #(
    .HALT_FETCHES(HALT_FETCHES)
  ) monitor (
    .clock        (clock),
    .reset_n      (reset_n),
    .ibus_rrequest(ibus_rrequest),
    .ibus_address (ibus_address),
    .dbus_wrequest(dbus_wrequest),
    .dbus_address (dbus_address),
    .dbus_wdata   (dbus_wdata),
    .done         (program_done)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic feedback;
    feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    return feedback;
  endfunction

  // 1 to MAX_DELAY cycles from two bits
  function automatic int response_delay();
    int delay;
    delay = 1;
    delay = delay + lfsr_bit();
    delay = delay + 2 * lfsr_bit();
    return delay;
  endfunction

  function automatic word_t fill_word(input word_t address);
    return {address[15:0], ~address[31:16]} ^ 32'h6b1d_3a55;
  endfunction

  function automatic word_t fetch_word(input word_t address);
    word_t offset;
    offset = address - BOOT_ADDRESS;
    if (offset < word_t'(MEMORY_WORDS * 4)) begin
      return program_memory[offset >> 2];
    end
    return fill_word(address);
  endfunction

  task automatic add_row(input word_t word, input bit fetched, input bit store,
                         input word_t address, input word_t data);
    table_word.push_back(word);
    table_fetched.push_back(fetched);
    table_store.push_back(store);
    table_store_address.push_back(address);
    table_store_data.push_back(data);
  endtask

  // Word, fetched, store, store address, store data
  task automatic load_program();
    add_row(32'h0000_1537, 1, 0, 0, 0);                        // lui  x10, 0x1
    add_row(32'h1234_50b7, 1, 0, 0, 0);                        // lui  x1, 0x12345
    add_row(32'hffb0_0113, 1, 0, 0, 0);                        // addi x2, x0, -5
    add_row(32'h0070_0193, 1, 0, 0, 0);                        // addi x3, x0, 7
    add_row(32'h0030_8233, 1, 0, 0, 0);                        // add  x4, x1, x3
    add_row(32'h0045_2023, 1, 1, 32'h0000_1000, 32'h1234_5007); // sw x4, 0(x10)
    add_row(32'h4021_82b3, 1, 0, 0, 0);                        // sub  x5, x3, x2
    add_row(32'h0055_2223, 1, 1, 32'h0000_1004, 32'h0000_000c); // sw x5, 4(x10)
    add_row(32'h0031_2333, 1, 0, 0, 0);                        // slt  x6, x2, x3
    add_row(32'h0065_2423, 1, 1, 32'h0000_1008, 32'h0000_0001); // sw x6, 8(x10)
    add_row(32'h0031_33b3, 1, 0, 0, 0);                        // sltu x7, x2, x3
    add_row(32'h0075_2623, 1, 1, 32'h0000_100c, 32'h0000_0000); // sw x7, 12(x10)
    add_row(32'h4011_5413, 1, 0, 0, 0);                        // srai x8, x2, 1
    add_row(32'h0085_2823, 1, 1, 32'h0000_1010, 32'hffff_fffd); // sw x8, 16(x10)
    add_row(32'h0041_5493, 1, 0, 0, 0);                        // srli x9, x2, 4
    add_row(32'h0095_2a23, 1, 1, 32'h0000_1014, 32'h0fff_ffff); // sw x9, 20(x10)
    add_row(32'h01c1_9593, 1, 0, 0, 0);                        // slli x11, x3, 28
    add_row(32'hfff5_c613, 1, 0, 0, 0);                        // xori x12, x11, -1
    add_row(32'h00c5_2c23, 1, 1, 32'h0000_1018, 32'h8fff_ffff); // sw x12, 24(x10)
    add_row(32'h0631_8013, 1, 0, 0, 0);                        // addi x0, x3, 99
    add_row(32'h0005_2e23, 1, 1, 32'h0000_101c, 32'h0000_0000); // sw x0, 28(x10)
    add_row(32'h0021_8463, 1, 0, 0, 0);                        // beq  x3, x2, +8
    add_row(32'h0021_9463, 1, 0, 0, 0);                        // bne  x3, x2, +8
    add_row(32'h0215_2023, 0, 0, 0, 0);                        // sw x1, 32(x10)
    add_row(32'h0031_8463, 1, 0, 0, 0);                        // beq  x3, x3, +8
    add_row(32'h0225_2223, 0, 0, 0, 0);                        // sw x2, 36(x10)
    add_row(32'h0042_1463, 1, 0, 0, 0);                        // bne  x4, x4, +8
    add_row(32'h0032_e6b3, 1, 0, 0, 0);                        // or   x13, x5, x3
    add_row(32'h0056_f713, 1, 0, 0, 0);                        // andi x14, x13, 5
    add_row(32'h02e5_2423, 1, 1, 32'h0000_1028, 32'h0000_0005); // sw x14, 40(x10)
    add_row(32'h0031_97b3, 1, 0, 0, 0);                        // sll  x15, x3, x3
    add_row(32'h02f5_2623, 1, 1, 32'h0000_102c, 32'h0000_0380); // sw x15, 44(x10)
    add_row(32'h0000_0063, 1, 0, 0, 0);                        // beq  x0, x0, 0
  endtask

  initial begin : main_sequence
    int row;
    reset_n = 1'b0;
    load_program();
    for (row = 0; row < MEMORY_WORDS; row++) begin
      program_memory[row] = fill_word(BOOT_ADDRESS + PC_STEP * word_t'(row));
    end
    for (row = 0; row < table_word.size(); row++) begin
      program_memory[row] = table_word[row];
      if (table_fetched[row]) begin
        monitor.expect_fetch(BOOT_ADDRESS + PC_STEP * word_t'(row));
      end
      if (table_store[row]) begin
        monitor.expect_store(table_store_address[row], table_store_data[row]);
      end
    end
    repeat (RESET_CYCLES) @(negedge clock);
    reset_n = 1'b1;
    wait (program_done);
    @(negedge clock);
    monitor.close_report();
    if (monitor.error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Instruction memory, answers each read after a random delay
  initial begin : ibus_responder
    int delay;
    ibus_rresponse = 1'b0;
    ibus_rdata     = '0;
    forever begin
      @(negedge clock);
      if (ibus_rrequest === 1'b1) begin
        delay = response_delay();
        repeat (delay) @(negedge clock);
        ibus_rdata     = fetch_word(ibus_address);
        ibus_rresponse = 1'b1;
        @(negedge clock);
        ibus_rresponse = 1'b0;
      end
    end
  end

  initial begin : dbus_responder
    int delay;
    dbus_wresponse = 1'b0;
    forever begin
      @(negedge clock);
      if (dbus_wrequest === 1'b1) begin
        delay = response_delay();
        repeat (delay) @(negedge clock);
        dbus_wresponse = 1'b1;
        @(negedge clock);
        dbus_wresponse = 1'b0;
      end
    end
  end

  // Worst case per row is one fetch and one store at full delay
  initial begin : watchdog
    int budget;
    @(posedge reset_n);
    budget = (table_word.size() + HALT_FETCHES) * 2 * (MAX_DELAY + 3);
    repeat (budget) @(posedge clock);
    $display("Timeout: the program did not finish within %0d cycles", budget);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/rv_core_pkg.sv
src/fetch_ctrl_if.sv
src/decode_if.sv
src/rv_fetch_unit.sv
src/rv_decoder.sv
src/rv_register_file.sv
src/rv_execute_stage.sv
src/rv_store_port.sv
src/rv_core_top.sv
test/rv_core_checker.sv
test/tb_rv_core.sv
